// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address split, tag | index | byte offset
`define CACHE_TAG_W 5
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 3

`define CACHE_WORD_W 16

// geometry of one way
`define CACHE_SETS 256
`define CACHE_LINE_WORDS 4

// main memory banking and per-access busy time
`define MEM_BANKS 4
`define MEM_LATENCY 4

// initial memory contents are word address xor this key
`define MEM_INIT_KEY 16'h5A3C

`endif

// ==== cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// address fields as the cache sees them
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_OFFSET_W-1:0] offset;
	} cache_fields_t;

	// same word read as a flat memory address or as cache fields
	typedef union packed {
		logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] flat;
		cache_fields_t f;
	} cache_addr_t;

	// controller states
	// wr_* handle the write-miss memory update,
	// evict_* the dirty victim, fill_* the line refill
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_MEM,
		ST_WR_WAIT,
		ST_EVICT,
		ST_EVICT_WAIT,
		ST_FILL,
		ST_FILL_WAIT
	} ctrl_state_t;

endpackage

// ==== cache_if.sv ====
`include "cache_config.svh"

// controller to one cache way
interface cache_way_if import cache_pkg::*; ();
	logic en;
	logic compare;
	logic write;
	logic [`CACHE_TAG_W-1:0] tag_in;
	logic [`CACHE_INDEX_W-1:0] index;
	logic [`CACHE_OFFSET_W-1:0] offset;
	word_t data_in;
	logic valid_in;

	// lookup results for the addressed set
	logic [`CACHE_TAG_W-1:0] tag_out;
	word_t data_out;
	logic hit;
	logic dirty;
	logic valid_out;

	modport ctrl (
		output en, compare, write, tag_in, index, offset, data_in, valid_in,
		input tag_out, data_out, hit, dirty, valid_out
	);

	modport way (
		input en, compare, write, tag_in, index, offset, data_in, valid_in,
		output tag_out, data_out, hit, dirty, valid_out
	);
endinterface

// controller to banked main memory
interface mem_bus_if import cache_pkg::*; ();
	logic [$bits(cache_addr_t)-1:0] addr;
	word_t wdata;
	logic read;
	logic write;
	word_t rdata;
	logic stall;

	modport master (output addr, wdata, read, write, input rdata, stall);

	modport slave (input addr, wdata, read, write, output rdata, stall);
endinterface

// ==== cache_way.sv ====
`include "cache_config.svh"

module cache_way import cache_pkg::*; (
	input logic clk,
	input logic rst,
	cache_way_if.way bus
);
	localparam int WSEL_W = $clog2(`CACHE_LINE_WORDS);

	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_SETS];
	word_t data_mem [`CACHE_SETS][`CACHE_LINE_WORDS];
	logic [`CACHE_SETS-1:0] valid_bits;
	logic [`CACHE_SETS-1:0] dirty_bits;

	logic [WSEL_W-1:0] word_sel;
	logic tag_match;
	logic do_write;
	logic fill_write;

	// byte offset bit 0 is never used for a word
	assign word_sel = bus.offset[`CACHE_OFFSET_W-1:1];
	assign tag_match = (tag_mem[bus.index] == bus.tag_in);

	// combinational lookup
	assign bus.tag_out = tag_mem[bus.index];
	assign bus.data_out = data_mem[bus.index][word_sel];
	assign bus.valid_out = valid_bits[bus.index];
	assign bus.dirty = dirty_bits[bus.index];
	assign bus.hit = valid_bits[bus.index] & tag_match;

	// compare writes need a hit, direct writes always land
	assign do_write = bus.en & bus.write & (bus.compare ? bus.hit : 1'b1);
	assign fill_write = bus.en & bus.write & ~bus.compare;

	always_ff @(posedge clk) begin
		if (do_write) begin
			data_mem[bus.index][word_sel] <= bus.data_in;
		end
		if (fill_write) begin
			tag_mem[bus.index] <= bus.tag_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (do_write) begin
			// hit write marks the line dirty, a fill word leaves it clean
			dirty_bits[bus.index] <= bus.compare;
			if (fill_write) begin
				valid_bits[bus.index] <= bus.valid_in;
			end
		end
	end

endmodule

// ==== cache_lru.sv ====
`include "cache_config.svh"

module cache_lru (
	input logic clk,
	input logic rst,
	input logic touch,
	input logic touch_way,
	input logic [`CACHE_INDEX_W-1:0] index,
	output logic victim
);
	// one bit per set, names the way to replace next
	logic [`CACHE_SETS-1:0] lru_bits;

	always_ff @(posedge clk) begin
		if (rst) begin
			lru_bits <= '0;
		end else if (touch) begin
			// the way not touched becomes the victim
			lru_bits[index] <= ~touch_way;
		end
	end

	assign victim = lru_bits[index];

endmodule

// ==== main_mem.sv ====
`include "cache_config.svh"

module main_mem import cache_pkg::*; (
	input logic clk,
	input logic rst,
	mem_bus_if.slave bus
);
	localparam int WADDR_W = $bits(cache_addr_t) - 1;
	localparam int BANK_W = $clog2(`MEM_BANKS);
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	word_t mem_array [2**WADDR_W];
	logic [CNT_W-1:0] busy_cnt [`MEM_BANKS];
	logic [BANK_W-1:0] last_bank;
	logic [WADDR_W-1:0] waddr;
	logic [BANK_W-1:0] bank_sel;
	logic accept;
	word_t rdata_q;

	// byte address to word address, low word bits pick the bank
	assign waddr = bus.addr[WADDR_W:1];
	assign bank_sel = waddr[BANK_W-1:0];
	assign accept = bus.read | bus.write;

	initial begin
		for (int i = 0; i < 2**WADDR_W; i++) begin
			mem_array[i] = word_t'(i) ^ `MEM_INIT_KEY;
		end
	end

	// per-bank busy timers
	always_ff @(posedge clk) begin
		if (rst) begin
			last_bank <= '0;
			for (int b = 0; b < `MEM_BANKS; b++) begin
				busy_cnt[b] <= '0;
			end
		end else begin
			for (int b = 0; b < `MEM_BANKS; b++) begin
				if (accept && bank_sel == BANK_W'(b)) begin
					busy_cnt[b] <= CNT_W'(`MEM_LATENCY);
				end else if (busy_cnt[b] != '0) begin
					busy_cnt[b] <= busy_cnt[b] - 1'b1;
				end
			end
			if (accept) begin
				last_bank <= bank_sel;
			end
		end
	end

	// writes land at acceptance, read data waits in rdata_q
	always_ff @(posedge clk) begin
		if (bus.write) begin
			mem_array[waddr] <= bus.wdata;
		end
		if (bus.read) begin
			rdata_q <= mem_array[waddr];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.stall = (busy_cnt[last_bank] != '0);

endmodule

// ==== cache_controller.sv ====
`include "cache_config.svh"

module cache_controller import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic wr,
	input cache_addr_t addr,
	input word_t data_in,
	output word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	cache_way_if.ctrl way0,
	cache_way_if.ctrl way1,
	input logic victim,
	output logic lru_touch,
	output logic lru_way,
	mem_bus_if.master mem
);
	localparam int CNT_W = $clog2(`CACHE_LINE_WORDS);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic [CNT_W-1:0] word_cnt;
	logic fill_way;
	logic need_evict;
	word_t data_q;
	word_t data_next;

	logic req;
	logic unaligned;
	logic any_hit;
	logic mem_ready;
	logic last_word;
	logic pick_way;
	logic pick_evict;
	logic [`CACHE_OFFSET_W-1:0] word_offset;
	logic [`CACHE_TAG_W-1:0] old_tag;

	logic [1:0] way_en;
	logic way_compare;
	logic way_write;
	logic way_valid_in;
	logic [`CACHE_OFFSET_W-1:0] way_offset;
	word_t way_wdata;
	cache_addr_t bus_addr;
	logic mem_rd;
	logic mem_wr;
	word_t mem_wdata;

	assign req = rd | wr;
	assign unaligned = addr.f.offset[0];
	assign any_hit = way0.hit | way1.hit;
	assign mem_ready = ~mem.stall;
	assign last_word = (word_cnt == CNT_W'(`CACHE_LINE_WORDS - 1));
	assign word_offset = {word_cnt, 1'b0};
	assign old_tag = fill_way ? way1.tag_out : way0.tag_out;

	// an empty way beats the LRU victim
	assign pick_way = ~way0.valid_out ? 1'b0 : (~way1.valid_out ? 1'b1 : victim);
	assign pick_evict = way0.valid_out & way1.valid_out & (victim ? way1.dirty : way0.dirty);

	always_comb begin
		state_next = state;
		way_en = 2'b00;
		way_compare = 1'b0;
		way_write = 1'b0;
		way_valid_in = 1'b0;
		way_offset = addr.f.offset;
		way_wdata = data_in;
		bus_addr = addr;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		mem_wdata = data_in;
		done = 1'b0;
		err = 1'b0;
		cache_hit = 1'b0;
		lru_touch = 1'b0;
		lru_way = fill_way;
		data_next = data_q;
		case (state)
			ST_IDLE: begin
				if (req && unaligned) begin
					done = 1'b1;
					err = 1'b1;
				end else if (req) begin
					// tag compare in both ways, a write hit updates in place
					way_en = 2'b11;
					way_compare = 1'b1;
					way_write = wr;
					if (any_hit) begin
						done = 1'b1;
						cache_hit = 1'b1;
						lru_touch = 1'b1;
						lru_way = way1.hit;
						if (!wr) begin
							data_next = way1.hit ? way1.data_out : way0.data_out;
						end
					end else if (wr) begin
						state_next = ST_WR_MEM;
					end else begin
						state_next = pick_evict ? ST_EVICT : ST_FILL;
					end
				end
			end
			ST_WR_MEM: begin
				mem_wr = 1'b1;
				state_next = ST_WR_WAIT;
			end
			ST_WR_WAIT: begin
				if (mem_ready) begin
					state_next = need_evict ? ST_EVICT : ST_FILL;
				end
			end
			ST_EVICT: begin
				// old line goes back under its own tag
				way_en = fill_way ? 2'b10 : 2'b01;
				way_offset = word_offset;
				bus_addr.f.tag = old_tag;
				bus_addr.f.offset = word_offset;
				mem_wdata = fill_way ? way1.data_out : way0.data_out;
				mem_wr = 1'b1;
				state_next = ST_EVICT_WAIT;
			end
			ST_EVICT_WAIT: begin
				if (mem_ready) begin
					state_next = last_word ? ST_FILL : ST_EVICT;
				end
			end
			ST_FILL: begin
				bus_addr.f.offset = word_offset;
				mem_rd = 1'b1;
				state_next = ST_FILL_WAIT;
			end
			ST_FILL_WAIT: begin
				if (mem_ready) begin
					way_en = fill_way ? 2'b10 : 2'b01;
					way_write = 1'b1;
					way_offset = word_offset;
					way_wdata = mem.rdata;
					// line turns valid with its last word
					way_valid_in = last_word;
					if (rd && !wr && addr.f.offset[`CACHE_OFFSET_W-1:1] == word_cnt) begin
						data_next = mem.rdata;
					end
					if (last_word) begin
						done = 1'b1;
						lru_touch = 1'b1;
						state_next = ST_IDLE;
					end else begin
						state_next = ST_FILL;
					end
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			word_cnt <= '0;
			fill_way <= 1'b0;
			need_evict <= 1'b0;
		end else begin
			state <= state_next;
			if (state == ST_IDLE) begin
				word_cnt <= '0;
				fill_way <= pick_way;
				need_evict <= pick_evict;
			end else if ((state == ST_EVICT_WAIT || state == ST_FILL_WAIT) && mem_ready) begin
				// wraps to zero after the last evicted word
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q <= data_next;
	end

	assign data_out = data_next;
	assign stall = (state != ST_IDLE);

	// both ways see the same address and data
	assign way0.en = way_en[0];
	assign way1.en = way_en[1];
	assign way0.compare = way_compare;
	assign way1.compare = way_compare;
	assign way0.write = way_write;
	assign way1.write = way_write;
	assign way0.tag_in = addr.f.tag;
	assign way1.tag_in = addr.f.tag;
	assign way0.index = addr.f.index;
	assign way1.index = addr.f.index;
	assign way0.offset = way_offset;
	assign way1.offset = way_offset;
	assign way0.data_in = way_wdata;
	assign way1.data_in = way_wdata;
	assign way0.valid_in = way_valid_in;
	assign way1.valid_in = way_valid_in;

	assign mem.addr = bus_addr.flat;
	assign mem.wdata = mem_wdata;
	assign mem.read = mem_rd;
	assign mem.write = mem_wr;

endmodule

// ==== mem_system.sv ====
`include "cache_config.svh"

module mem_system (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic wr,
	input logic [15:0] addr,
	input logic [`CACHE_WORD_W-1:0] data_in,
	output logic [`CACHE_WORD_W-1:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);
	logic victim;
	logic lru_touch;
	logic lru_way;

	cache_way_if way0_bus ();
	cache_way_if way1_bus ();
	mem_bus_if mem_bus ();

	cache_controller i_controller (
		.clk(clk),
		.rst(rst),
		.rd(rd),
		.wr(wr),
		.addr(addr),
		.data_in(data_in),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.way0(way0_bus.ctrl),
		.way1(way1_bus.ctrl),
		.victim(victim),
		.lru_touch(lru_touch),
		.lru_way(lru_way),
		.mem(mem_bus.master)
	);

	cache_way way_0 (.clk(clk), .rst(rst), .bus(way0_bus.way));

	cache_way way_1 (.clk(clk), .rst(rst), .bus(way1_bus.way));

	// both ways carry the same index
	cache_lru i_lru (
		.clk(clk),
		.rst(rst),
		.touch(lru_touch),
		.touch_way(lru_way),
		.index(way0_bus.index),
		.victim(victim)
	);

	main_mem i_mem (.clk(clk), .rst(rst), .bus(mem_bus.slave));

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic rst
);
	// period of 8
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for 8 cycles, released just after an edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
	end
endmodule

// ==== tb_mem_system.sv ====
`include "cache_config.svh"

module tb_mem_system import cache_pkg::*; ();
	localparam int ADDR_W = `CACHE_TAG_W + `CACHE_INDEX_W + `CACHE_OFFSET_W;
	localparam int WORDS = 2**(ADDR_W - 1);
	localparam int MAX_OPS = 64;
	localparam int NUM_RANDOM = 40;
	localparam int RAND_INDEX [4] = '{5, 9, 17, 200};

	logic clk;
	logic rst;
	logic rd;
	logic wr;
	logic [ADDR_W-1:0] addr;
	word_t data_in;
	word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;
	ctrl_state_t ctrl_state;

	// operation table with expected columns from the reference model
	string tbl_name [MAX_OPS];
	logic tbl_wr [MAX_OPS];
	logic [ADDR_W-1:0] tbl_addr [MAX_OPS];
	word_t tbl_wdata [MAX_OPS];
	word_t tbl_exp_data [MAX_OPS];
	logic tbl_exp_hit [MAX_OPS];
	logic tbl_exp_err [MAX_OPS];
	int num_ops = 0;

	// reference model of memory contents and cache tags
	word_t shadow_mem [WORDS];
	logic model_valid [`CACHE_SETS][2];
	logic [`CACHE_TAG_W-1:0] model_tag [`CACHE_SETS][2];
	logic model_lru [`CACHE_SETS];
	// data_out keeps the last read word across writes
	word_t last_read_data = '0;

	int unsigned lcg_state = 32'd80230;
	int cycle_count = 0;
	int cycle_limit = 0;
	int check_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock_gen i_clk_gen (.clk(clk), .rst(rst));

	mem_system i_dut (
		.clk(clk),
		.rst(rst),
		.rd(rd),
		.wr(wr),
		.addr(addr),
		.data_in(data_in),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	assign ctrl_state = i_dut.i_controller.state;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// low bits of an LCG cycle too quickly
		return lcg_state >> 8;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(int tag, int index, int word);
		return {tag[`CACHE_TAG_W-1:0], index[`CACHE_INDEX_W-1:0], word[`CACHE_OFFSET_W-2:0], 1'b0};
	endfunction

	task automatic model_reset();
		for (int i = 0; i < WORDS; i++) begin
			shadow_mem[i] = word_t'(i) ^ `MEM_INIT_KEY;
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			model_valid[s][0] = 1'b0;
			model_valid[s][1] = 1'b0;
			model_tag[s][0] = '0;
			model_tag[s][1] = '0;
			model_lru[s] = 1'b0;
		end
	endtask

	// predicts a hit and allocates a miss into an empty way or the LRU way
	function automatic logic model_access(logic [ADDR_W-1:0] a);
		logic [`CACHE_TAG_W-1:0] t;
		logic [`CACHE_INDEX_W-1:0] idx;
		logic hit;
		int way;
		t = a[ADDR_W-1 -: `CACHE_TAG_W];
		idx = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[idx][w] && model_tag[idx][w] == t) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			if (!model_valid[idx][0]) begin
				way = 0;
			end else if (!model_valid[idx][1]) begin
				way = 1;
			end else begin
				way = int'(model_lru[idx]);
			end
			model_valid[idx][way] = 1'b1;
			model_tag[idx][way] = t;
		end
		model_lru[idx] = (way == 0);
		return hit;
	endfunction

	task automatic add_op(input string name, input logic is_wr, input logic [ADDR_W-1:0] a,
			input word_t wd);
		tbl_name[num_ops] = name;
		tbl_wr[num_ops] = is_wr;
		tbl_addr[num_ops] = a;
		tbl_wdata[num_ops] = wd;
		tbl_exp_err[num_ops] = a[0];
		tbl_exp_hit[num_ops] = 1'b0;
		tbl_exp_data[num_ops] = '0;
		if (!a[0]) begin
			tbl_exp_hit[num_ops] = model_access(a);
			if (is_wr) begin
				shadow_mem[a[ADDR_W-1:1]] = wd;
				tbl_exp_data[num_ops] = last_read_data;
			end else begin
				last_read_data = shadow_mem[a[ADDR_W-1:1]];
				tbl_exp_data[num_ops] = last_read_data;
			end
		end
		num_ops++;
	endtask

	task automatic build_table();
		int unsigned r;
		int tag;
		int sel;
		int word;
		logic is_wr;
		word_t wd;
		add_op("rd_cold", 1'b0, make_addr(1, 5, 0), '0);
		add_op("rd_same_line_w2", 1'b0, make_addr(1, 5, 2), '0);
		add_op("rd_same_line_w0", 1'b0, make_addr(1, 5, 0), '0);
		add_op("wr_hit", 1'b1, make_addr(1, 5, 1), 16'hBEEF);
		add_op("rd_after_wr_hit", 1'b0, make_addr(1, 5, 1), '0);
		add_op("wr_miss", 1'b1, make_addr(2, 9, 3), 16'h1234);
		add_op("rd_after_wr_miss", 1'b0, make_addr(2, 9, 3), '0);
		// three tags fight over set 5 while tag 1 holds the dirty word
		add_op("evict_fill_tag2", 1'b0, make_addr(2, 5, 0), '0);
		add_op("evict_touch_tag1", 1'b0, make_addr(1, 5, 3), '0);
		add_op("evict_fill_tag3", 1'b0, make_addr(3, 5, 0), '0);
		add_op("evict_keep_tag1", 1'b0, make_addr(1, 5, 1), '0);
		add_op("evict_refill_tag2", 1'b0, make_addr(2, 5, 2), '0);
		add_op("evict_dirty_tag1", 1'b0, make_addr(4, 5, 0), '0);
		add_op("dirty_readback", 1'b0, make_addr(1, 5, 1), '0);
		add_op("unaligned_rd", 1'b0, make_addr(1, 5, 1) | 16'h0001, '0);
		add_op("unaligned_wr", 1'b1, make_addr(2, 9, 3) | 16'h0001, 16'hDEAD);
		add_op("rd_after_err", 1'b0, make_addr(1, 5, 1), '0);
		add_op("rd_after_err_wr", 1'b0, make_addr(2, 9, 3), '0);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = lcg_next();
			tag = int'(r % 6);
			sel = int'((r / 6) % 4);
			word = int'((r / 24) % 4);
			is_wr = ((r / 96) % 3) == 0;
			r = lcg_next();
			wd = word_t'(r);
			add_op($sformatf("rand_%0d", i), is_wr, make_addr(tag, RAND_INDEX[sel], word), wd);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			check_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			check_errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (check_errors == errors_before) begin
			$display("[ok]   %s", name);
		end else begin
			tests_failed++;
			$display("[bad]  %s with %0d mismatches", name, check_errors - errors_before);
		end
	endtask

	// drives one table entry until done and then releases it
	task automatic run_op(input int k);
		int waited;
		int errors_before;
		logic done_seen;
		word_t got_data;
		logic got_hit;
		logic got_err;
		logic got_stall;
		errors_before = check_errors;
		@(posedge clk);
		#1;
		rd = !tbl_wr[k];
		wr = tbl_wr[k];
		addr = tbl_addr[k];
		data_in = tbl_wdata[k];
		waited = 0;
		done_seen = 1'b0;
		while (!done_seen) begin
			@(negedge clk);
			waited++;
			done_seen = done;
		end
		got_data = data_out;
		got_hit = cache_hit;
		got_err = err;
		got_stall = stall;
		check_flag({tbl_name[k], " err"}, tbl_exp_err[k], got_err);
		check_flag({tbl_name[k], " cache_hit"}, tbl_exp_hit[k], got_hit);
		if (!tbl_exp_err[k]) begin
			check_word({tbl_name[k], " data_out"}, tbl_exp_data[k], got_data);
		end
		// hits and errors answer at once while misses stall
		if (tbl_exp_err[k] || tbl_exp_hit[k]) begin
			check_flag({tbl_name[k], " single cycle"}, 1'b1, waited == 1);
			check_flag({tbl_name[k], " stall at done"}, 1'b0, got_stall);
		end else begin
			check_flag({tbl_name[k], " stall at done"}, 1'b1, got_stall);
		end
		@(posedge clk);
		#1;
		rd = 1'b0;
		wr = 1'b0;
		@(negedge clk);
		check_flag({tbl_name[k], " stall after done"}, 1'b0, stall);
		report_test(tbl_name[k], errors_before);
	endtask

	// run limit scales with the table length
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT never finished, controller in %s",
				cycle_count, ctrl_state.name());
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int errors_before;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		model_reset();
		build_table();
		cycle_limit = 200 * num_ops + 100;
		wait (rst === 1'b0);
		@(negedge clk);
		errors_before = check_errors;
		check_flag("reset stall", 1'b0, stall);
		check_flag("reset done", 1'b0, done);
		check_flag("reset err", 1'b0, err);
		check_flag("reset cache_hit", 1'b0, cache_hit);
		report_test("reset_state", errors_before);
		for (int k = 0; k < num_ops; k++) begin
			run_op(k);
		end
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, check_errors);
		if (tests_failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
cache_pkg.sv
cache_if.sv
cache_way.sv
cache_lru.sv
main_mem.sv
cache_controller.sv
mem_system.sv
tb_clock_gen.sv
tb_mem_system.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mem_system
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing -j $(JOBS)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
